// File: logic/elink_cfg_consts.svh
// elink configuration endpoint constants
// packet width, local chip id, address groups and register indices
`ifndef ELINK_CFG_CONSTS_SVH
`define ELINK_CFG_CONSTS_SVH

// mesh packet width in bits
`define CFG_PW 104

// local chip id, compared against dstaddr[31:20]
`define CFG_CHIP_ID 12'h999

// address groups in dstaddr[19:16]
`define CFG_GROUP_MMU 4'hD
`define CFG_GROUP_RR 4'hE
`define CFG_GROUP_MMR 4'hF

// config register file, index from addr[4:3]
`define CFG_REG_VERSION 2'd0
`define CFG_REG_CTRL 2'd1
`define CFG_REG_SCRATCH 2'd2

// countdown timer, index from addr[4:3]
`define TMR_REG_CFG 2'd0
`define TMR_REG_LOAD 2'd1
`define TMR_REG_COUNT 2'd2

// fixed version word, read only
`define CFG_VERSION_VAL 32'h0001_0203

`endif

// File: logic/elink_cfg_pkg.sv
// elink configuration endpoint types
// vector types for the mesh packet fields and the register bus
`default_nettype none

`include "elink_cfg_consts.svh"

package elink_cfg_pkg;

   // mesh address, chip id in [31:20], group in [19:16]
   typedef logic [31:0] addr_t;

   // mesh data word
   typedef logic [31:0] data_t;

   // transfer size code
   typedef logic [1:0] datamode_t;

   // transaction control bits
   typedef logic [3:0] ctrlmode_t;

   // whole packet, write flag in bit 0
   typedef logic [`CFG_PW-1:0] packet_t;

   // chip id field
   typedef logic [11:0] chip_id_t;

   // address group code
   typedef logic [3:0] group_t;

   // register bus address, low bits of dstaddr
   typedef logic [14:0] mi_addr_t;

   // register bus word, srcaddr over data
   typedef logic [63:0] mi_word_t;

   // register index within a target, addr[4:3]
   typedef logic [1:0] reg_idx_t;

endpackage

`default_nettype wire

// File: logic/mi_bus_if.sv
// register bus between the access decoder and the register targets
// one select per target, shared write strobe, address and data
`timescale 1ns/1ps
`default_nettype none

interface mi_bus_if;

   import elink_cfg_pkg::*;

   // target selects, one cycle wide
   logic     cfg_en;
   logic     timer_en;

   // shared request fields
   logic     we;
   mi_addr_t addr;
   mi_word_t din;

   // readback, zero when not selected for a read
   mi_word_t cfg_dout;
   mi_word_t timer_dout;

   // decoder side
   modport master (output cfg_en, timer_en, we, addr, din,
                   input  cfg_dout, timer_dout);

   // config register file side
   modport cfg_target (input  cfg_en, we, addr, din,
                       output cfg_dout);

   // timer side
   modport timer_target (input  timer_en, we, addr, din,
                         output timer_dout);

endinterface

`default_nettype wire

// File: logic/cfg_access_decoder.sv
// mesh access decoder for the configuration endpoint
// splits packets, selects a register target, forwards remote-group
// traffic and builds readback packets for local reads
`timescale 1ns/1ps
`default_nettype none

`include "elink_cfg_consts.svh"

module cfg_access_decoder
  #(parameter bit RX = 1'b0)
   (
   input  wire                     clk,
   input  wire                     nreset,
   input  wire                     access_in,
   input  wire elink_cfg_pkg::packet_t packet_in,
   input  wire                     wait_in,
   output logic                    access_out,
   output elink_cfg_pkg::packet_t  packet_out,
   mi_bus_if.master                mi
   );

   import elink_cfg_pkg::*;

   // incoming fields
   logic      write;
   datamode_t datamode;
   ctrlmode_t ctrlmode;
   addr_t     dstaddr;
   data_t     data;
   addr_t     srcaddr;
   chip_id_t  chip_id;
   group_t    group;

   // decode results
   logic      match;
   logic      cfg_hit;
   logic      timer_hit;
   logic      target_hit;
   logic      fwd_hit;
   logic      rd_hit;
   logic      rd_sel;
   mi_word_t  dout_mux;

   // output stage
   logic      access_out_reg;
   logic      readback_reg;
   logic      rb_live;
   mi_word_t  dout_hold;
   mi_word_t  rb_word;
   logic      write_reg;
   datamode_t datamode_reg;
   ctrlmode_t ctrlmode_reg;
   addr_t     dstaddr_reg;
   addr_t     srcaddr_reg;
   data_t     data_reg;
   addr_t     srcaddr_out;
   data_t     data_out;

   // packet split, bit 7 is always zero
   assign write    = packet_in[0];
   assign datamode = packet_in[2:1];
   assign ctrlmode = packet_in[6:3];
   assign dstaddr  = packet_in[39:8];
   assign data     = packet_in[71:40];
   assign srcaddr  = packet_in[103:72];

   assign chip_id = dstaddr[31:20];
   assign group   = dstaddr[19:16];

   // local packet, id match
   assign match = access_in & (chip_id == `CFG_CHIP_ID);

   // config regs at 0b01 plus RX in [10:8]
   assign cfg_hit = match & (group == `CFG_GROUP_MMR) & (dstaddr[10:8] == {2'b01, RX});

   // timer regs at 5 in [10:8], side picked by bit 5
   assign timer_hit = match & (group == `CFG_GROUP_MMR) & (dstaddr[10:8] == 3'h5) &
                      (dstaddr[5] == RX);

   assign target_hit = cfg_hit | timer_hit;
   assign rd_hit     = target_hit & ~write;

   // remote-group traffic nobody here claims
   assign fwd_hit = match & ~target_hit &
                    ((group == `CFG_GROUP_RR) | (group == `CFG_GROUP_MMR) |
                     (group == `CFG_GROUP_MMU));

   // bus drive, selects held off under wait
   assign mi.cfg_en   = cfg_hit & ~wait_in;
   assign mi.timer_en = timer_hit & ~wait_in;
   assign mi.we       = write & target_hit;
   assign mi.addr     = dstaddr[14:0];
   assign mi.din      = {srcaddr, data};

   // a read actually issued this cycle
   assign rd_sel = rd_hit & ~wait_in;

   // idle targets drive zero
   assign dout_mux = mi.cfg_dout | mi.timer_dout;

   // response strobe and readback tracking
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         access_out_reg <= 1'b0;
         readback_reg   <= 1'b0;
         rb_live        <= 1'b0;
      end
      else
      begin
         // dout is only valid the cycle after a select
         rb_live <= rd_sel;
         if (!wait_in)
         begin
            access_out_reg <= fwd_hit | rd_hit;
            readback_reg   <= rd_hit;
         end
      end
   end

   // outgoing header, frozen while wait_in is high
   always_ff @(posedge clk)
   begin
      if (!wait_in)
      begin
         write_reg    <= write | rd_hit;
         datamode_reg <= datamode;
         ctrlmode_reg <= ctrlmode;
         // readback goes back to the requester
         dstaddr_reg  <= rd_hit ? srcaddr : dstaddr;
         srcaddr_reg  <= srcaddr;
         data_reg     <= data;
      end
      // keep read data once the target drops it
      if (rb_live)
         dout_hold <= dout_mux;
   end

   assign rb_word     = rb_live ? dout_mux : dout_hold;
   assign srcaddr_out = readback_reg ? rb_word[63:32] : srcaddr_reg;
   assign data_out    = readback_reg ? rb_word[31:0] : data_reg;

   // masked so a stalled response is not seen twice
   assign access_out = access_out_reg & ~wait_in;

   assign packet_out = {srcaddr_out, data_out, dstaddr_reg, 1'b0,
                        ctrlmode_reg, datamode_reg, write_reg};

   // no response leaks through back-pressure
   a_no_access_on_wait: assert property (@(posedge clk) disable iff (!nreset)
      wait_in |-> !access_out);

   // register targets never share an address window
   a_one_target: assert property (@(posedge clk) disable iff (!nreset)
      !(mi.cfg_en && mi.timer_en));

endmodule

`default_nettype wire

// File: logic/cfg_reg_file.sv
// configuration register file
// read-only version, control word driven out, 64-bit scratch
`timescale 1ns/1ps
`default_nettype none

`include "elink_cfg_consts.svh"

module cfg_reg_file
   (
   input  wire                   clk,
   input  wire                   nreset,
   mi_bus_if.cfg_target          mi,
   output elink_cfg_pkg::data_t  cfg_ctrl
   );

   import elink_cfg_pkg::*;

   reg_idx_t idx;
   mi_word_t scratch;
   mi_word_t rdata;
   logic     wr_en;
   logic     rd_en;

   // register index within the window
   assign idx = mi.addr[4:3];

   assign wr_en = mi.cfg_en & mi.we;
   assign rd_en = mi.cfg_en & ~mi.we;

   // control word
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         cfg_ctrl <= '0;
      else if (wr_en && (idx == `CFG_REG_CTRL))
         cfg_ctrl <= mi.din[31:0];
   end

   // scratch takes srcaddr and data together
   always_ff @(posedge clk)
   begin
      if (wr_en && (idx == `CFG_REG_SCRATCH))
         scratch <= mi.din;
   end

   // read select
   always_comb
   begin
      case (idx)
         `CFG_REG_VERSION:
            // fixed version word
            rdata = {32'h0, `CFG_VERSION_VAL};
         `CFG_REG_CTRL:
            rdata = {32'h0, cfg_ctrl};
         `CFG_REG_SCRATCH:
            rdata = scratch;
         default:
            // unmapped
            rdata = '0;
      endcase
   end

   // readback, zero unless read this cycle
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         mi.cfg_dout <= '0;
      else if (rd_en)
         mi.cfg_dout <= rdata;
      else
         mi.cfg_dout <= '0;
   end

   // decoder select is always resolved
   a_cfg_en_known: assert property (@(posedge clk) disable iff (!nreset)
      !$isunknown(mi.cfg_en));

endmodule

`default_nettype wire

// File: logic/cfg_ctimer.sv
// countdown timer target on the register bus
// loadable count, auto-reload, one-cycle expiry pulse
`timescale 1ns/1ps
`default_nettype none

`include "elink_cfg_consts.svh"

module cfg_ctimer
   (
   input  wire              clk,
   input  wire              nreset,
   mi_bus_if.timer_target   mi,
   output logic             timer_irq
   );

   import elink_cfg_pkg::*;

   reg_idx_t idx;
   logic     wr_en;
   logic     rd_en;
   logic     load_wr;
   logic     tmr_en;
   logic     auto_reload;
   logic     dec;
   data_t    load_val;
   data_t    count;
   mi_word_t rdata;

   assign idx     = mi.addr[4:3];
   assign wr_en   = mi.timer_en & mi.we;
   assign rd_en   = mi.timer_en & ~mi.we;
   assign load_wr = wr_en & (idx == `TMR_REG_LOAD);

   // counting step, a load write wins
   assign dec = tmr_en & (count != '0) & ~load_wr;

   // config bits and start value
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         tmr_en      <= 1'b0;
         auto_reload <= 1'b0;
         load_val    <= '0;
      end
      else
      begin
         if (wr_en && (idx == `TMR_REG_CFG))
         begin
            tmr_en      <= mi.din[0];
            auto_reload <= mi.din[1];
         end
         if (load_wr)
            load_val <= mi.din[31:0];
      end
   end

   // count, irq one cycle after the 1 to 0 step
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         count     <= '0;
         timer_irq <= 1'b0;
      end
      else
      begin
         timer_irq <= dec & (count == 32'd1);
         if (load_wr)
            count <= mi.din[31:0];
         else if (dec)
            count <= count - 32'd1;
         else if (tmr_en && auto_reload)
            // expired, start over
            count <= load_val;
      end
   end

   // readback, count is live
   always_comb
   begin
      case (idx)
         `TMR_REG_CFG:
            rdata = {62'h0, auto_reload, tmr_en};
         `TMR_REG_LOAD:
            rdata = {32'h0, load_val};
         `TMR_REG_COUNT:
            rdata = {32'h0, count};
         default:
            rdata = '0;
      endcase
   end

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         mi.timer_dout <= '0;
      else
         mi.timer_dout <= rd_en ? rdata : '0;
   end

   // expiry is a single pulse even at load 1
   a_irq_pulse: assert property (@(posedge clk) disable iff (!nreset)
      timer_irq |=> !timer_irq);

endmodule

`default_nettype wire

// File: logic/elink_cfg_top.sv
// elink configuration endpoint top
// access decoder with the config register file and countdown timer
// RX picks the receive or transmit register window
`timescale 1ns/1ps
`default_nettype none

module elink_cfg_top
  #(parameter bit RX = 1'b0)
   (
   // clock and reset
   input  wire                         clk,
   input  wire                         nreset,

   // incoming mesh packet
   input  wire                         access_in,
   input  wire elink_cfg_pkg::packet_t packet_in,

   // outgoing readback or forwarded packet
   input  wire                         wait_in,
   output logic                        access_out,
   output elink_cfg_pkg::packet_t      packet_out,

   // register outputs
   output elink_cfg_pkg::data_t        cfg_ctrl,
   output logic                        timer_irq
   );

   // register bus
   mi_bus_if mi ();

   // packet decode and response build
   cfg_access_decoder
     #(.RX (RX))
   u_decoder
     (
      .clk        (clk),
      .nreset     (nreset),
      .access_in  (access_in),
      .packet_in  (packet_in),
      .wait_in    (wait_in),
      .access_out (access_out),
      .packet_out (packet_out),
      .mi         (mi.master)
     );

   // version, control and scratch
   cfg_reg_file u_reg_file
     (
      .clk      (clk),
      .nreset   (nreset),
      .mi       (mi.cfg_target),
      .cfg_ctrl (cfg_ctrl)
     );

   // countdown timer
   cfg_ctimer u_ctimer
     (
      .clk       (clk),
      .nreset    (nreset),
      .mi        (mi.timer_target),
      .timer_irq (timer_irq)
     );

endmodule

`default_nettype wire

// File: bench/tb_elink_cfg.sv
// directed testbench for the elink configuration endpoint
// register access, forwarding, back-pressure and the countdown timer
`timescale 1ns/1ps
`default_nettype none

`include "elink_cfg_consts.svh"

module tb_elink_cfg;

   import elink_cfg_pkg::*;

   localparam bit RX = 1'b0;
   localparam int RESP_TIMEOUT = 20;
   localparam int TMR_START = 20;
   // register windows in dstaddr[10:8]
   localparam logic [2:0] CFG_WIN = {2'b01, RX};
   localparam logic [2:0] TMR_WIN = 3'h5;

   logic        clk;
   logic        nreset;
   logic        access_in;
   packet_t     packet_in;
   logic        wait_in;
   logic        access_out;
   packet_t     packet_out;
   data_t       cfg_ctrl;
   logic        timer_irq;
   int          fail_count;
   int unsigned seed_val;
   // expected control register
   data_t       ctrl_exp;

   elink_cfg_top #(.RX (RX)) UUT
     (
      .clk        (clk),
      .nreset     (nreset),
      .access_in  (access_in),
      .packet_in  (packet_in),
      .wait_in    (wait_in),
      .access_out (access_out),
      .packet_out (packet_out),
      .cfg_ctrl   (cfg_ctrl),
      .timer_irq  (timer_irq)
     );

   // 20 ns clock
   always #10 clk = ~clk;

   // packet from its fields, bit 7 stays zero
   function automatic packet_t make_packet(input logic wr, input datamode_t dm,
      input ctrlmode_t cm, input addr_t dst, input data_t dat, input addr_t src);
      return {src, dat, dst, 1'b0, cm, dm, wr};
   endfunction

   // local MMR address, bit 5 zero selects the RX=0 timer side
   function automatic addr_t reg_addr(input logic [2:0] win, input reg_idx_t idx);
      return {`CFG_CHIP_ID, `CFG_GROUP_MMR, 5'h0, win, 3'h0, idx, 3'h0};
   endfunction

   task automatic report_failure(input string line);
      fail_count++;
      $display("%s", line);
      $display("Test failures found");
      $fatal(1, "simulation stopped at first error");
   endtask

   task automatic check_value(input logic [127:0] got, input logic [127:0] exp,
      input string what);
      if (got !== exp)
         report_failure($sformatf("Mismatch at time %0t: %s, got %0h expected %0h",
                                  $time, what, got, exp));
   endtask

   // one-cycle strobe on the next rising edge
   task automatic send_packet(input packet_t pkt);
      @(posedge clk);
      access_in <= 1'b1;
      packet_in <= pkt;
      @(posedge clk);
      access_in <= 1'b0;
      packet_in <= '0;
   endtask

   task automatic expect_none(input int cycles, input string what);
      int i;
      for (i = 0; i < cycles; i++)
      begin
         @(negedge clk);
         check_value(access_out, 1'b0, what);
      end
   endtask

   // latency counts idle cycles after the request edge
   task automatic wait_response(output packet_t resp, output int latency);
      int   i;
      logic seen;
      seen    = 1'b0;
      latency = 0;
      resp    = '0;
      for (i = 0; i < RESP_TIMEOUT && !seen; i++)
      begin
         @(negedge clk);
         if (access_out)
         begin
            seen = 1'b1;
            resp = packet_out;
         end
         else
            latency++;
      end
      if (!seen)
         report_failure($sformatf("Timeout at time %0t: access_out never rose", $time));
      // response strobe is one cycle
      @(negedge clk);
      check_value(access_out, 1'b0, "response strobe width");
   endtask

   task automatic expect_packet(input packet_t got, input packet_t exp, input string what);
      check_value(got[0], exp[0], {what, " write flag"});
      check_value(got[39:8], exp[39:8], {what, " dstaddr"});
      check_value(got, exp, {what, " packet"});
   endtask

   task automatic send_write(input addr_t addr, input data_t dat, input addr_t src);
      datamode_t dm;
      ctrlmode_t cm;
      dm = $urandom_range(3);
      cm = $urandom_range(15);
      send_packet(make_packet(1'b1, dm, cm, addr, dat, src));
      // a write gives no response
      expect_none(3, "write response");
   endtask

   task automatic send_read(input addr_t addr, input addr_t src, output packet_t req,
      output packet_t resp);
      datamode_t dm;
      ctrlmode_t cm;
      int        latency;
      dm  = $urandom_range(3);
      cm  = $urandom_range(15);
      req = make_packet(1'b0, dm, cm, addr, $urandom, src);
      send_packet(req);
      wait_response(resp, latency);
      check_value(latency, 0, "readback latency");
   endtask

   // readback header: back to the requester, dout split over srcaddr and data
   task automatic read_check(input addr_t addr, input mi_word_t exp_word, input string what);
      addr_t   src;
      packet_t req;
      packet_t resp;
      src = $urandom;
      send_read(addr, src, req, resp);
      expect_packet(resp, make_packet(1'b1, req[2:1], req[6:3], src, exp_word[31:0],
                                      exp_word[63:32]), what);
   endtask

   task automatic wait_irq(input int limit, input string what);
      int   i;
      logic seen;
      seen = 1'b0;
      for (i = 0; i < limit && !seen; i++)
      begin
         @(negedge clk);
         seen = timer_irq;
      end
      if (!seen)
         report_failure($sformatf("Timeout at time %0t: no timer_irq for %s", $time, what));
      @(negedge clk);
      check_value(timer_irq, 1'b0, "timer_irq pulse width");
   endtask

   task automatic reset_defaults();
      @(negedge clk);
      check_value(access_out, 1'b0, "access_out after reset");
      check_value(cfg_ctrl, 32'h0, "cfg_ctrl after reset");
      check_value(timer_irq, 1'b0, "timer_irq after reset");
      read_check(reg_addr(CFG_WIN, `CFG_REG_VERSION), {32'h0, `CFG_VERSION_VAL}, "version");
   endtask

   task automatic register_access();
      data_t val;
      addr_t src;
      int    i;
      for (i = 0; i < 3; i++)
      begin
         val = $urandom;
         send_write(reg_addr(CFG_WIN, `CFG_REG_CTRL), val, $urandom);
         ctrl_exp = val;
         check_value(cfg_ctrl, val, "cfg_ctrl after write");
         read_check(reg_addr(CFG_WIN, `CFG_REG_CTRL), {32'h0, val}, "control");
         // scratch keeps srcaddr too
         val = $urandom;
         src = $urandom;
         send_write(reg_addr(CFG_WIN, `CFG_REG_SCRATCH), val, src);
         read_check(reg_addr(CFG_WIN, `CFG_REG_SCRATCH), {src, val}, "scratch");
      end
      read_check(reg_addr(CFG_WIN, 2'd3), 64'h0, "unmapped config offset");
      read_check(reg_addr(TMR_WIN, 2'd3), 64'h0, "unmapped timer offset");
   endtask

   task automatic forward_and_drop();
      addr_t   fwd_addr [3];
      addr_t   dst;
      packet_t pkt;
      packet_t resp;
      int      latency;
      int      i;
      fwd_addr[0] = {`CFG_CHIP_ID, `CFG_GROUP_RR, 16'h0040};
      fwd_addr[1] = {`CFG_CHIP_ID, `CFG_GROUP_MMU, 16'h1000};
      // MMR address outside both windows
      fwd_addr[2] = {`CFG_CHIP_ID, `CFG_GROUP_MMR, 16'h0000};
      for (i = 0; i < 3; i++)
      begin
         pkt = make_packet(i[0], 2'd2, 4'h5, fwd_addr[i], $urandom, $urandom);
         send_packet(pkt);
         wait_response(resp, latency);
         check_value(latency, 0, "forward latency");
         expect_packet(resp, pkt, "forwarded");
      end
      // wrong id aimed at the control register
      dst = reg_addr(CFG_WIN, `CFG_REG_CTRL);
      dst[31:20] = 12'h123;
      send_packet(make_packet(1'b1, 2'd0, 4'h0, dst, ~ctrl_exp, $urandom));
      expect_none(4, "wrong id write");
      check_value(cfg_ctrl, ctrl_exp, "cfg_ctrl after wrong id write");
      send_packet(make_packet(1'b0, 2'd0, 4'h0, dst, $urandom, $urandom));
      expect_none(4, "wrong id read");
      // foreign group, right id
      dst = {`CFG_CHIP_ID, 4'h3, 16'h0208};
      send_packet(make_packet(1'b0, 2'd1, 4'h2, dst, $urandom, $urandom));
      expect_none(4, "foreign group read");
   endtask

   task automatic back_pressure();
      packet_t req;
      packet_t resp;
      addr_t   src;
      int      latency;
      int      i;
      // held read
      src = $urandom;
      req = make_packet(1'b0, 2'd1, 4'h9, reg_addr(CFG_WIN, `CFG_REG_CTRL), 32'h0, src);
      @(posedge clk);
      wait_in   <= 1'b1;
      access_in <= 1'b1;
      packet_in <= req;
      expect_none(4, "read under wait");
      @(posedge clk);
      wait_in <= 1'b0;
      @(posedge clk);
      access_in <= 1'b0;
      packet_in <= '0;
      wait_response(resp, latency);
      check_value(latency, 0, "latency after release");
      expect_packet(resp, make_packet(1'b1, 2'd1, 4'h9, src, ctrl_exp, 32'h0), "held read");
      // held write
      @(posedge clk);
      wait_in   <= 1'b1;
      access_in <= 1'b1;
      packet_in <= make_packet(1'b1, 2'd2, 4'h1, reg_addr(CFG_WIN, `CFG_REG_CTRL), ~ctrl_exp,
                               $urandom);
      for (i = 0; i < 4; i++)
      begin
         @(negedge clk);
         check_value(cfg_ctrl, ctrl_exp, "cfg_ctrl under wait");
      end
      @(posedge clk);
      wait_in <= 1'b0;
      @(posedge clk);
      access_in <= 1'b0;
      packet_in <= '0;
      ctrl_exp = ~ctrl_exp;
      @(negedge clk);
      check_value(cfg_ctrl, ctrl_exp, "cfg_ctrl after release");
      expect_none(3, "held write response");
   endtask

   task automatic timer_countdown();
      packet_t req;
      packet_t resp;
      int      i;
      send_write(reg_addr(TMR_WIN, `TMR_REG_LOAD), TMR_START, $urandom);
      send_write(reg_addr(TMR_WIN, `TMR_REG_CFG), 32'h1, $urandom);
      send_read(reg_addr(TMR_WIN, `TMR_REG_COUNT), $urandom, req, resp);
      check_value(resp[71:40] < TMR_START, 1'b1, "live count below load");
      check_value(resp[39:8], req[103:72], "count readback dstaddr");
      wait_irq(TMR_START + 3, "one-shot expiry");
      // stopped at zero
      for (i = 0; i < 2 * TMR_START; i++)
      begin
         @(negedge clk);
         check_value(timer_irq, 1'b0, "timer_irq without auto-reload");
      end
      // auto-reload from the stored start value
      send_write(reg_addr(TMR_WIN, `TMR_REG_CFG), 32'h3, $urandom);
      wait_irq(TMR_START + 3, "first reload expiry");
      wait_irq(TMR_START + 3, "second reload expiry");
      send_write(reg_addr(TMR_WIN, `TMR_REG_CFG), 32'h0, $urandom);
   endtask

   initial
   begin
      seed_val   = $urandom(60217);
      fail_count = 0;
      ctrl_exp   = '0;
      clk        = 1'b0;
      nreset     = 1'b0;
      access_in  = 1'b0;
      packet_in  = '0;
      wait_in    = 1'b0;
      repeat (5) @(posedge clk);
      nreset <= 1'b1;
      reset_defaults();
      register_access();
      forward_and_drop();
      back_pressure();
      timer_countdown();
      if (fail_count == 0)
         $display("All tests passed!");
      else
         $display("Test failures found");
      $finish;
   end

endmodule

`default_nettype wire

// File: compile.f
+incdir+logic
logic/elink_cfg_pkg.sv
logic/mi_bus_if.sv
logic/cfg_access_decoder.sv
logic/cfg_reg_file.sv
logic/cfg_ctimer.sv
logic/elink_cfg_top.sv
bench/tb_elink_cfg.sv
